/* Bender.yml */
package:
  name: mac_tx_arbiter

sources:
  # package first, then the pipeline stages and the top level
  - src/mac_tx_pkg.sv
  - src/frame_rr_arbiter.sv
  - src/frame_byte_fifo.sv
  - src/mac_tx_frame_tracker.sv
  - src/mac_tx_arbiter.sv
  - target: simulation
    files:
      - verif/tb_mac_tx_arbiter.sv

/* compile.f */
src/mac_tx_pkg.sv
src/frame_rr_arbiter.sv
src/frame_byte_fifo.sv
src/mac_tx_frame_tracker.sv
src/mac_tx_arbiter.sv
verif/tb_mac_tx_arbiter.sv

/* src/frame_byte_fifo.sv */
`default_nettype none

module frame_byte_fifo #(
    parameter int unsigned FIFO_ADDR_W = 5
) (
    input  logic                   i_txmac_clk,
    input  logic                   i_txmac_srst,
    input  logic                   i_wr_en,
    input  mac_tx_pkg::fifo_word_t i_wr_word,
    input  logic                   i_rd_en,
    output logic                   o_full,
    output logic                   o_empty,
    output mac_tx_pkg::fifo_word_t o_rd_word,
    output logic                   o_rd_vld
);
    import mac_tx_pkg::*;

    localparam int unsigned DEPTH = 2 ** FIFO_ADDR_W;

    fifo_word_t           mem [DEPTH];
    // pointers carry one extra wrap bit above the address
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 rd_accept;

    // same address, different lap means full
    assign o_full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                     (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);
    assign o_empty = (wr_ptr == rd_ptr);

    // reads on an empty fifo are dropped here
    assign rd_accept = i_rd_en & ~o_empty;

    // storage, writer already holds off when full
    always_ff @(posedge i_txmac_clk) begin
        if (i_wr_en) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= i_wr_word;
        end
    end

    // registered read data, holds until the next accepted read
    always_ff @(posedge i_txmac_clk) begin
        if (rd_accept) begin
            o_rd_word <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
    end

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_rd_vld <= 1'b0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // one-cycle strobe alongside fresh read data
            o_rd_vld <= rd_accept;
        end
    end

endmodule

`default_nettype wire

/* src/frame_rr_arbiter.sv */
`default_nettype none

module frame_rr_arbiter #(
    parameter int unsigned NUM_INPUTS = 2
) (
    input  logic                                   i_txmac_clk,
    input  logic                                   i_txmac_srst,
    input  mac_tx_pkg::eth_byte_t [NUM_INPUTS-1:0] i_src_byte,
    input  logic                  [NUM_INPUTS-1:0] i_src_byte_vld,
    input  logic                  [NUM_INPUTS-1:0] i_src_last_byte,
    input  logic                                   i_fifo_full,
    output logic                  [NUM_INPUTS-1:0] o_src_byte_rd,
    output logic                                   o_wr_en,
    output mac_tx_pkg::fifo_word_t                 o_wr_word
);
    import mac_tx_pkg::*;

    // index needs at least one bit even with a single source
    localparam int unsigned IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    arb_state_e            state;
    logic [NUM_INPUTS-1:0] grant;
    logic [NUM_INPUTS-1:0] grant_mask;
    logic [NUM_INPUTS-1:0] req_masked;
    logic [NUM_INPUTS-1:0] pick_raw;
    logic [NUM_INPUTS-1:0] pick_masked;
    logic [IDX_W-1:0]      src_idx;
    logic                  byte_taken;
    logic                  last_taken;
    eth_byte_t             src_data;

    // isolate the lowest set bit, source 0 has priority
    function automatic logic [NUM_INPUTS-1:0] lowest_set(input logic [NUM_INPUTS-1:0] req);
        logic [NUM_INPUTS-1:0] neg;
        neg = ~req + 1'b1;
        return req & neg;
    endfunction

    // sources already served in this rotation are masked out
    assign req_masked  = i_src_byte_vld & ~grant_mask;
    assign pick_raw    = lowest_set(i_src_byte_vld);
    assign pick_masked = lowest_set(req_masked);

    // one-hot grant to binary index for the byte mux
    always_comb begin
        src_idx = '0;
        for (int unsigned i = 0; i < NUM_INPUTS; i++) begin
            if (grant[i]) begin
                src_idx = IDX_W'(i);
            end
        end
    end

    // read strobe is the grant, held off while the fifo is full
    assign o_src_byte_rd = grant & ~{NUM_INPUTS{i_fifo_full}};

    // a byte moves when the granted source is valid and we read it
    assign byte_taken = o_src_byte_rd[src_idx] & i_src_byte_vld[src_idx];
    assign last_taken = byte_taken & i_src_last_byte[src_idx];
    assign src_data   = i_src_byte[src_idx];

    assign o_wr_en        = byte_taken;
    assign o_wr_word.last = i_src_last_byte[src_idx];
    assign o_wr_word.data = src_data;

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            grant_mask <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // restart the rotation from the raw requests
                    grant      <= pick_raw;
                    grant_mask <= pick_raw;
                    state      <= (|i_src_byte_vld) ? ARB_FRAME : ARB_IDLE;
                end
                ARB_FRAME: begin
                    // grant only moves on a frame boundary
                    if (last_taken) begin
                        grant      <= pick_masked;
                        grant_mask <= grant_mask | pick_masked;
                        // nothing left unmasked, drop grant for a cycle
                        state      <= (|req_masked) ? ARB_FRAME : ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mac_tx_arbiter.sv */
`default_nettype none

module mac_tx_arbiter #(
    parameter int unsigned NUM_INPUTS        = 2,
    // how many maximum-size frames the fifo must hold
    parameter int unsigned MAX_FRAME_BUFFERS = 5,
    parameter int unsigned MAX_FRAME_BYTES   = mac_tx_pkg::ETH_FRAME_MAX_BYTES
) (
    input  logic                                   i_txmac_clk,
    input  logic                                   i_txmac_srst,
    input  mac_tx_pkg::eth_byte_t [NUM_INPUTS-1:0] i_src_byte,
    input  logic                  [NUM_INPUTS-1:0] i_src_byte_vld,
    input  logic                  [NUM_INPUTS-1:0] i_src_last_byte,
    output logic                  [NUM_INPUTS-1:0] o_src_byte_rd,
    input  logic                                   i_tx_macread,
    output logic                                   o_tx_fifoavail,
    output logic                                   o_tx_fifoeof,
    output logic                                   o_tx_fifoempty,
    output mac_tx_pkg::eth_byte_t                  o_tx_fifodata
);
    import mac_tx_pkg::*;

    // depth rounds up to the next power of two
    localparam int unsigned FIFO_ADDR_W = $clog2(MAX_FRAME_BUFFERS * MAX_FRAME_BYTES);

    logic       wr_en;
    fifo_word_t wr_word;
    logic       fifo_full;
    fifo_word_t rd_word;
    logic       rd_vld;

    // stage 1, whole-frame round robin into the fifo write port
    frame_rr_arbiter #(
        .NUM_INPUTS      (NUM_INPUTS)
    ) frame_rr_arbiter_inst (
        .i_txmac_clk     (i_txmac_clk),
        .i_txmac_srst    (i_txmac_srst),
        .i_src_byte      (i_src_byte),
        .i_src_byte_vld  (i_src_byte_vld),
        .i_src_last_byte (i_src_last_byte),
        .i_fifo_full     (fifo_full),
        .o_src_byte_rd   (o_src_byte_rd),
        .o_wr_en         (wr_en),
        .o_wr_word       (wr_word)
    );

    // stage 2, byte buffer read by the mac
    frame_byte_fifo #(
        .FIFO_ADDR_W  (FIFO_ADDR_W)
    ) frame_byte_fifo_inst (
        .i_txmac_clk  (i_txmac_clk),
        .i_txmac_srst (i_txmac_srst),
        .i_wr_en      (wr_en),
        .i_wr_word    (wr_word),
        .i_rd_en      (i_tx_macread),
        .o_full       (fifo_full),
        .o_empty      (o_tx_fifoempty),
        .o_rd_word    (rd_word),
        .o_rd_vld     (rd_vld)
    );

    // stage 3, frame bookkeeping on the mac side
    mac_tx_frame_tracker #(
        .FIFO_ADDR_W    (FIFO_ADDR_W)
    ) mac_tx_frame_tracker_inst (
        .i_txmac_clk    (i_txmac_clk),
        .i_txmac_srst   (i_txmac_srst),
        .i_wr_en        (wr_en),
        .i_wr_last      (wr_word.last),
        .i_fifo_empty   (o_tx_fifoempty),
        .i_rd_word      (rd_word),
        .i_rd_vld       (rd_vld),
        .o_tx_fifoavail (o_tx_fifoavail),
        .o_tx_fifoeof   (o_tx_fifoeof),
        .o_tx_fifodata  (o_tx_fifodata)
    );

endmodule

`default_nettype wire

/* src/mac_tx_frame_tracker.sv */
`default_nettype none

module mac_tx_frame_tracker #(
    parameter int unsigned FIFO_ADDR_W = 5
) (
    input  logic                   i_txmac_clk,
    input  logic                   i_txmac_srst,
    input  logic                   i_wr_en,
    input  logic                   i_wr_last,
    input  logic                   i_fifo_empty,
    input  mac_tx_pkg::fifo_word_t i_rd_word,
    input  logic                   i_rd_vld,
    output logic                   o_tx_fifoavail,
    output logic                   o_tx_fifoeof,
    output mac_tx_pkg::eth_byte_t  o_tx_fifodata
);

    // complete frames currently held in the fifo
    logic [FIFO_ADDR_W-1:0] frame_cnt;
    logic                   frame_in;
    logic                   frame_out;

    // a last byte written closes a frame on the input side
    assign frame_in  = i_wr_en & i_wr_last;

    // eof only on the cycle a fresh word is presented,
    // held read data never repeats the pulse
    assign o_tx_fifoeof = i_rd_vld & i_rd_word.last;
    assign frame_out    = o_tx_fifoeof;

    // data byte toward the mac, flag stripped off
    assign o_tx_fifodata = i_rd_word.data;

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            frame_cnt <= '0;
        end else begin
            case ({frame_in, frame_out})
                2'b10: begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
                2'b01: begin
                    frame_cnt <= frame_cnt - 1'b1;
                end
                default: begin
                    // no change, or one in and one out together
                    frame_cnt <= frame_cnt;
                end
            endcase
        end
    end

    // a whole frame is buffered and the fifo still has bytes for it
    assign o_tx_fifoavail = (|frame_cnt) & ~i_fifo_empty;

endmodule

`default_nettype wire

/* src/mac_tx_pkg.sv */
`default_nettype none

package mac_tx_pkg;

    // one frame byte as it leaves a source
    localparam int unsigned ETH_BYTE_W = 8;

    typedef logic [ETH_BYTE_W-1:0] eth_byte_t;

    // fifo entry, last-byte flag sits above the data byte
    typedef struct packed {
        logic      last;
        eth_byte_t data;
    } fifo_word_t;

    // largest frame without fcs, the mac inserts the checksum itself
    localparam int unsigned ETH_FRAME_MAX_BYTES = 1514;

    // arbiter state
    // idle: nobody holds the grant
    // frame: grant held until the granted source hands over its last byte
    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_FRAME = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

/* verif/mac_tx_arbiter_vectors.txt */
// frame table in hex, one frame per line
// test  source  length  first_byte  output_position
02 01 08 10 00
03 00 06 20 00
03 00 09 40 02
03 00 04 60 04
03 01 07 a0 01
03 01 05 b0 03
03 01 0c c0 05
04 00 10 00 00
04 00 10 30 02
04 01 08 80 01
05 00 04 70 00
05 01 05 90 01

/* verif/tb_mac_tx_arbiter.sv */
`default_nettype none

module tb_mac_tx_arbiter;
    import mac_tx_pkg::*;

    localparam int NUM_SRC     = 2;
    // 2 buffers of 16 bytes round up to 32 entries
    localparam int FIFO_DEPTH  = 32;
    localparam int MAX_ROWS    = 32;
    localparam int MODE_OFF    = 0;
    localparam int MODE_ALWAYS = 1;
    localparam int MODE_RANDOM = 2;
    localparam int WAIT_TAKEN  = 0;
    localparam int WAIT_FRAMES = 1;
    localparam int WAIT_DRAIN  = 2;

    logic                    i_txmac_clk;
    logic                    i_txmac_srst;
    eth_byte_t [NUM_SRC-1:0] i_src_byte;
    logic      [NUM_SRC-1:0] i_src_byte_vld;
    logic      [NUM_SRC-1:0] i_src_last_byte;
    logic      [NUM_SRC-1:0] o_src_byte_rd;
    logic                    i_tx_macread;
    logic                    o_tx_fifoavail;
    logic                    o_tx_fifoeof;
    logic                    o_tx_fifoempty;
    eth_byte_t               o_tx_fifodata;

    // five bytes per row for test, source, length, first byte and output position
    logic [7:0] vec_mem [0:MAX_ROWS*5-1];
    // queued words are {last, byte}
    logic [8:0] src0_q[$];
    logic [8:0] src1_q[$];
    logic [8:0] exp_q[$];
    string      test_name = "none";
    int         read_mode = MODE_OFF;
    integer     rand_seed = 32'hd273_b22f;
    // running counts of the bench's own model
    int         taken_cnt = 0;
    int         read_cnt = 0;
    int         wr_frames = 0;
    int         eof_frames = 0;
    logic       word_pending = 1'b0;
    int         base;

    mac_tx_arbiter #(
        .NUM_INPUTS        (NUM_SRC),
        .MAX_FRAME_BUFFERS (2),
        .MAX_FRAME_BYTES   (16)
    ) mac_tx_arbiter_inst (
        .i_txmac_clk     (i_txmac_clk),
        .i_txmac_srst    (i_txmac_srst),
        .i_src_byte      (i_src_byte),
        .i_src_byte_vld  (i_src_byte_vld),
        .i_src_last_byte (i_src_last_byte),
        .o_src_byte_rd   (o_src_byte_rd),
        .i_tx_macread    (i_tx_macread),
        .o_tx_fifoavail  (o_tx_fifoavail),
        .o_tx_fifoeof    (o_tx_fifoeof),
        .o_tx_fifoempty  (o_tx_fifoempty),
        .o_tx_fifodata   (o_tx_fifodata)
    );

    initial begin
        i_txmac_clk = 1'b0;
        forever begin
            #10 i_txmac_clk = ~i_txmac_clk;
        end
    end

    task automatic stop_on_mismatch(input string what, input int expected, input int actual);
        $display("error: %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_with_reason(input string reason);
        $display("%s: %s", test_name, reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    // byte k of the frame in a table row with the last flag on its final byte
    function automatic logic [8:0] frame_word(input int row, input int k);
        return {k == vec_mem[row*5+2] - 1, vec_mem[row*5+3] + 8'(k)};
    endfunction

    task automatic load_frames(input int test_no);
        int row;
        int pos;
        int k;
        // source queues keep the file order of each source
        for (row = 0; row < MAX_ROWS; row++) begin
            for (k = 0; vec_mem[row*5] == test_no && k < vec_mem[row*5+2]; k++) begin
                if (vec_mem[row*5+1] == 0) begin
                    src0_q.push_back(frame_word(row, k));
                end else begin
                    src1_q.push_back(frame_word(row, k));
                end
            end
        end
        // expected stream in output position order
        for (pos = 0; pos < MAX_ROWS; pos++) begin
            for (row = 0; row < MAX_ROWS; row++) begin
                for (k = 0; vec_mem[row*5] == test_no && vec_mem[row*5+4] == pos &&
                            k < vec_mem[row*5+2]; k++) begin
                    exp_q.push_back(frame_word(row, k));
                end
            end
        end
    endtask

    function automatic bit goal_met(input int kind, input int target);
        case (kind)
            WAIT_TAKEN:  return taken_cnt >= target;
            WAIT_FRAMES: return wr_frames >= target;
            default:     return exp_q.size() + src0_q.size() + src1_q.size() == 0;
        endcase
    endfunction

    task automatic wait_for(input int kind, input int target, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!goal_met(kind, target)) begin
            @(negedge i_txmac_clk);
            cycles++;
            if (cycles > limit) begin
                stop_with_reason(what);
            end
        end
        // frame count settles one cycle after the last eof
        @(negedge i_txmac_clk);
    endtask

    task automatic check_quiet();
        assert ({o_tx_fifoempty, o_tx_fifoavail} == 2'b10)
            else stop_on_mismatch("empty and avail after drain", 2,
                                  {o_tx_fifoempty, o_tx_fifoavail});
    endtask

    task automatic run_frames(input string name, input int test_no, input int mode);
        @(negedge i_txmac_clk);
        test_name = name;
        read_mode = mode;
        load_frames(test_no);
        wait_for(WAIT_DRAIN, 0, 3000, "output stream never drained");
        check_quiet();
    endtask

    // source models, mac reader and per-cycle checks share one process
    always @(posedge i_txmac_clk) begin : bench_model
        int          occ;
        int          open_frames;
        logic        want_avail;
        logic [8:0]  want;
        logic [8:0]  word;
        logic [31:0] rnd;
        occ         = taken_cnt - read_cnt;
        open_frames = wr_frames - eof_frames;
        want_avail  = (open_frames != 0) && (occ != 0);
        if (!i_txmac_srst) begin
            assert (o_tx_fifoempty == (occ == 0))
                else stop_on_mismatch("fifo empty flag", occ == 0, o_tx_fifoempty);
            assert (o_tx_fifoavail == want_avail)
                else stop_on_mismatch("frame available flag", want_avail, o_tx_fifoavail);
            if (occ >= FIFO_DEPTH) begin
                assert (o_src_byte_rd == '0)
                    else stop_on_mismatch("source read while full", 0, o_src_byte_rd);
            end
            // word of the read accepted at the previous edge
            if (word_pending) begin
                assert (exp_q.size() != 0)
                    else stop_with_reason("an output byte came that no frame expected");
                want = exp_q.pop_front();
                assert (o_tx_fifodata == want[7:0])
                    else stop_on_mismatch("output byte", want[7:0], o_tx_fifodata);
                assert (o_tx_fifoeof == want[8])
                    else stop_on_mismatch("end of frame pulse", want[8], o_tx_fifoeof);
                eof_frames += want[8];
            end else begin
                assert (!o_tx_fifoeof)
                    else stop_on_mismatch("end of frame without read", 0, o_tx_fifoeof);
            end
            word_pending = i_tx_macread && !o_tx_fifoempty;
            read_cnt += word_pending;
            // byte moves on valid and read
            for (int s = 0; s < NUM_SRC; s++) begin
                if (i_src_byte_vld[s] && o_src_byte_rd[s]) begin
                    taken_cnt++;
                    wr_frames += i_src_last_byte[s];
                    if (s == 0) begin
                        src0_q.delete(0);
                    end else begin
                        src1_q.delete(0);
                    end
                end
            end
        end
        // present the head of each queue back to back
        word = (src0_q.size() != 0) ? src0_q[0] : 9'h000;
        i_src_byte_vld[0]  <= (src0_q.size() != 0);
        i_src_last_byte[0] <= word[8];
        i_src_byte[0]      <= word[7:0];
        word = (src1_q.size() != 0) ? src1_q[0] : 9'h000;
        i_src_byte_vld[1]  <= (src1_q.size() != 0);
        i_src_last_byte[1] <= word[8];
        i_src_byte[1]      <= word[7:0];
        rnd = $random(rand_seed);
        i_tx_macread <= (read_mode == MODE_ALWAYS) ||
                        (read_mode == MODE_RANDOM && rnd[1:0] != 2'b00);
    end

    initial begin
        i_txmac_srst    = 1'b1;
        i_src_byte      = '0;
        i_src_byte_vld  = '0;
        i_src_last_byte = '0;
        i_tx_macread    = 1'b0;
        for (int i = 0; i < MAX_ROWS * 5; i++) begin
            vec_mem[i] = 8'h00;
        end
        $readmemh("verif/mac_tx_arbiter_vectors.txt", vec_mem);
        repeat (16) @(posedge i_txmac_clk);
        i_txmac_srst <= 1'b0;

        // quiet outputs with no source valid
        test_name = "reset_state";
        repeat (10) begin
            @(negedge i_txmac_clk);
            assert ({o_tx_fifoempty, o_src_byte_rd, o_tx_fifoavail, o_tx_fifoeof} == 5'b10000)
                else stop_on_mismatch("empty, read, avail, eof", 5'b10000,
                                      {o_tx_fifoempty, o_src_byte_rd,
                                       o_tx_fifoavail, o_tx_fifoeof});
        end

        run_frames("single_frame", 2, MODE_ALWAYS);
        run_frames("round_robin", 3, MODE_ALWAYS);

        // fifo fills with the mac stalled and then drains in order
        @(negedge i_txmac_clk);
        test_name = "back_pressure";
        read_mode = MODE_OFF;
        base = taken_cnt;
        load_frames(4);
        wait_for(WAIT_TAKEN, base + FIFO_DEPTH, 500, "fifo never filled");
        repeat (8) begin
            @(negedge i_txmac_clk);
            assert (o_src_byte_rd == '0)
                else stop_on_mismatch("source read while full", 0, o_src_byte_rd);
        end
        assert (taken_cnt == base + FIFO_DEPTH)
            else stop_on_mismatch("bytes taken", base + FIFO_DEPTH, taken_cnt);
        read_mode = MODE_ALWAYS;
        wait_for(WAIT_DRAIN, 0, 3000, "output stream never drained");
        check_quiet();

        // two whole frames buffered before the first read
        @(negedge i_txmac_clk);
        test_name = "frame_count";
        read_mode = MODE_OFF;
        base = wr_frames;
        load_frames(5);
        wait_for(WAIT_FRAMES, base + 2, 500, "two frames never buffered");
        assert (o_tx_fifoavail) else stop_on_mismatch("frame available", 1, o_tx_fifoavail);
        read_mode = MODE_ALWAYS;
        wait_for(WAIT_DRAIN, 0, 3000, "output stream never drained");
        check_quiet();

        run_frames("random_reads", 3, MODE_RANDOM);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
